/* project.f */
rtl/apb_pkg.sv
rtl/delay_pkg.sv
rtl/apb_delayer.sv
rtl/apb_wait_regs.sv
rtl/apb_perf_counter.sv
rtl/apb_delay_top.sv
testbench/apb_delay_asserts.sv
testbench/tb_apb_delay_top.sv

/* Bender.yml */
package:
  name: apb_delay_stretcher

sources:
  - rtl/apb_pkg.sv
  - rtl/delay_pkg.sv
  - rtl/apb_delayer.sv
  - rtl/apb_wait_regs.sv
  - rtl/apb_perf_counter.sv
  - rtl/apb_delay_top.sv
  - target: simulation
    files:
      - testbench/apb_delay_asserts.sv
      - testbench/tb_apb_delay_top.sv

/* testbench/tb_apb_delay_top.sv */
`timescale 1ns/1ps

module tb_apb_delay_top
    import apb_pkg::*;
    import delay_pkg::*;
();

    // Tests 1 to 5 issue 32, 32, 16, 24 and 40 transfers.
    localparam int planned_transfers = 144;
    localparam int timeout_cycles    = planned_transfers * 50 + 100;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pslverr;
        logic [31:0] latency;
    } result_t;

    logic         clock;
    logic         reset;
    apb_req_t     req;
    apb_rsp_t     rsp;
    perf_counts_t counts;

    logic [31:0]  model_mem [reg_count];
    result_t      expected_q [$];
    result_t      actual_q [$];
    event         result_ready;

    int           seed = 14167;
    int           cycle_count = 0;
    int           check_count = 0;
    int           error_count = 0;
    int           test_count = 0;
    int           test_check_base;
    int           test_error_base;
    string        current_test = "none";
    logic [31:0]  stall_expected;

    apb_delay_top apb_delay_top_inst (
        .clock  (clock),
        .reset  (reset),
        .req    (req),
        .rsp    (rsp),
        .counts (counts)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
                     current_test, what, expected, actual);
        end
    endtask

    // Expected response from the word model, the wait rule and the latency rule.
    function automatic result_t expected_response(input logic [31:0] addr,
                                                  input logic write);
        result_t    r;
        logic [1:0] w;
        r = '0;
        if (addr >= 32'h0000_0040) begin
            r.pslverr = 1'b1;
            r.latency = 32'd2;
        end else begin
            w = addr[3:2];
            r.latency = (ratio + 1) * w + 2;
            if (!write) begin
                r.prdata = model_mem[addr[5:2]];
            end
        end
        return r;
    endfunction

    function automatic void update_model(input logic [31:0] addr, input logic [31:0] wdata,
                                         input logic [3:0] strb);
        if (addr < 32'h0000_0040) begin
            for (int b = 0; b < strb_width; b++) begin
                if (strb[b]) begin
                    model_mem[addr[5:2]][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
    endfunction

    task automatic apply_reset();
        @(negedge clock);
        reset = 1'b1;
        req = '0;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < reg_count; i++) begin
            model_mem[i] = '0;
        end
        stall_expected = '0;
    endtask

    // One APB transfer, setup then access until pready.
    task automatic run_transfer(input logic [31:0] addr, input logic write,
                                input logic [31:0] wdata, input logic [3:0] strb);
        result_t exp_r;
        result_t act_r;
        int      start_cycle;
        exp_r = expected_response(addr, write);
        @(negedge clock);
        req.paddr   = addr;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pprot   = 3'd0;
        req.pwrite  = write;
        req.pwdata  = write ? wdata : '0;
        req.pstrb   = write ? strb : '0;
        @(negedge clock);
        req.penable = 1'b1;
        start_cycle = cycle_count;
        @(negedge clock);
        while (!rsp.pready) begin
            @(negedge clock);
        end
        act_r.prdata  = rsp.prdata;
        act_r.pslverr = rsp.pslverr;
        act_r.latency = cycle_count - start_cycle;
        expected_q.push_back(exp_r);
        actual_q.push_back(act_r);
        -> result_ready;
        if (write) begin
            update_model(addr, wdata, strb);
        end
        stall_expected = stall_expected + exp_r.latency;
        // Requester holds the request through the pready edge.
        @(negedge clock);
        req = '0;
    endtask

    initial begin
        result_t exp_r;
        result_t act_r;
        forever begin
            @(result_ready);
            while (actual_q.size() > 0) begin
                exp_r = expected_q.pop_front();
                act_r = actual_q.pop_front();
                check_value("prdata", exp_r.prdata, act_r.prdata);
                check_value("pslverr", exp_r.pslverr, act_r.pslverr);
                check_value("latency", exp_r.latency, act_r.latency);
            end
        end
    end

    task automatic start_test(input string name);
        current_test = name;
        test_check_base = check_count;
        test_error_base = error_count;
    endtask

    task automatic finish_test();
        test_count++;
        $display("Test %s: %0d checks, %0d errors", current_test,
                 check_count - test_check_base, error_count - test_error_base);
    endtask

    initial begin
        logic [31:0] pick;
        logic [31:0] addr;
        logic [3:0]  strb;
        int unsigned assert_failures;
        reset = 1'b1;
        req = '0;
        apply_reset();

        start_test("reset_and_readback");
        check_value("rsp pready", 32'd0, rsp.pready);
        check_value("rsp prdata", 32'd0, rsp.prdata);
        check_value("transfers", 32'd0, counts.transfers);
        check_value("stall_cycles", 32'd0, counts.stall_cycles);
        for (int i = 0; i < reg_count; i++) begin
            run_transfer(32'(i * 4), 1'b1, $random(seed), 4'hf);
        end
        for (int i = 0; i < reg_count; i++) begin
            run_transfer(32'(i * 4), 1'b0, '0, '0);
        end
        finish_test();

        start_test("partial_strobes");
        for (int i = 0; i < reg_count; i++) begin
            pick = $random(seed);
            strb = pick[3:0];
            if (strb == 4'hf) begin
                strb = 4'h6;
            end
            run_transfer(32'(i * 4), 1'b1, $random(seed), strb);
        end
        for (int i = 0; i < reg_count; i++) begin
            run_transfer(32'(i * 4), 1'b0, '0, '0);
        end
        finish_test();

        start_test("wait_latency");
        for (int i = reg_count - 1; i >= 0; i--) begin
            run_transfer(32'(i * 4), 1'b0, '0, '0);
        end
        finish_test();

        start_test("out_of_range");
        for (int k = 0; k < 8; k++) begin
            pick = $random(seed);
            addr = 32'h0000_0040 | {22'd0, pick[23:16], 2'b00};
            if (k == 7) begin
                addr = 32'hffff_fffc;
            end
            run_transfer(addr, (k % 2) == 0, pick, 4'hf);
        end
        for (int i = 0; i < reg_count; i++) begin
            run_transfer(32'(i * 4), 1'b0, '0, '0);
        end
        finish_test();

        start_test("random_mix");
        apply_reset();
        check_value("transfers", 32'd0, counts.transfers);
        check_value("stall_cycles", 32'd0, counts.stall_cycles);
        for (int n = 0; n < 40; n++) begin
            pick = $random(seed);
            if (pick[2:0] == 3'd0) begin
                addr = 32'h0000_0040 | {22'd0, pick[23:16], 2'b00};
            end else begin
                addr = {26'd0, pick[11:8], 2'b00};
            end
            run_transfer(addr, pick[4], $random(seed), pick[31:28]);
        end
        @(negedge clock);
        check_value("transfers", 32'd40, counts.transfers);
        check_value("stall_cycles", stall_expected, counts.stall_cycles);
        finish_test();

        repeat (2) @(negedge clock);
        assert_failures = apb_delay_top_inst.apb_delayer_inst.apb_delay_asserts_inst.failure_count;
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_count, check_count, error_count, assert_failures);
        if ((error_count == 0) && (assert_failures == 0)) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* testbench/apb_delay_asserts.sv */
`timescale 1ns/1ps

module apb_delay_asserts
    import apb_pkg::*;
    import delay_pkg::*;
(
    input logic         clock,
    input logic         reset,
    input apb_req_t     req,
    input apb_rsp_t     rsp,
    input delay_state_t state
);

    // Read by the testbench summary.
    int unsigned failure_count = 0;

    // The response is a single-cycle pulse.
    pready_pulse: assert property (@(posedge clock) disable iff (reset)
        rsp.pready |=> !rsp.pready)
        else begin
            failure_count++;
            $error("rsp pready stayed high for two cycles");
        end

    pready_in_access: assert property (@(posedge clock) disable iff (reset)
        rsp.pready |-> (req.psel && req.penable))
        else begin
            failure_count++;
            $error("rsp pready high outside an access phase");
        end

    prdata_quiet: assert property (@(posedge clock) disable iff (reset)
        !rsp.pready |-> (rsp.prdata == '0))
        else begin
            failure_count++;
            $error("rsp prdata not zero while pready is low");
        end

    // FSM leaves reset in idle.
    state_after_reset: assert property (@(posedge clock)
        reset |=> (state == idle))
        else begin
            failure_count++;
            $error("delayer state not idle after reset");
        end

endmodule

bind apb_delayer apb_delay_asserts apb_delay_asserts_inst (
    .clock (clock),
    .reset (reset),
    .req   (req),
    .rsp   (rsp),
    .state (state)
);

/* rtl/apb_delay_top.sv */
`timescale 1ns/1ps

module apb_delay_top
    import apb_pkg::*;
    import delay_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  apb_req_t     req,
    output apb_rsp_t     rsp,
    output perf_counts_t counts
);

    apb_req_t dev_req;
    apb_rsp_t dev_rsp;

    apb_delayer apb_delayer_inst (
        .clock   (clock),
        .reset   (reset),
        .req     (req),
        .rsp     (rsp),
        .dev_req (dev_req),
        .dev_rsp (dev_rsp)
    );

    apb_wait_regs apb_wait_regs_inst (
        .clock (clock),
        .reset (reset),
        .req   (dev_req),
        .rsp   (dev_rsp)
    );

    // Watches the requester side only.
    apb_perf_counter apb_perf_counter_inst (
        .clock  (clock),
        .reset  (reset),
        .req    (req),
        .rsp    (rsp),
        .counts (counts)
    );

endmodule

/* rtl/apb_perf_counter.sv */
`timescale 1ns/1ps

module apb_perf_counter
    import apb_pkg::*;
    import delay_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  apb_req_t     req,
    input  apb_rsp_t     rsp,
    output perf_counts_t counts
);

    logic completed;
    logic stalled;

    // A transfer ends with the requester-side pready.
    assign completed = rsp.pready;

    // Access phase cycles that are not yet answered.
    assign stalled = req.psel && req.penable && !rsp.pready;

    always_ff @(posedge clock) begin
        if (reset) begin
            counts.transfers <= '0;
        end else if (completed) begin
            counts.transfers <= counts.transfers + 32'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            counts.stall_cycles <= '0;
        end else if (stalled) begin
            counts.stall_cycles <= counts.stall_cycles + 32'd1;
        end
    end

endmodule

/* rtl/apb_wait_regs.sv */
`timescale 1ns/1ps

module apb_wait_regs
    import apb_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  apb_req_t req,
    output apb_rsp_t rsp
);

    logic [data_width-1:0]        mem [reg_count];
    logic [$clog2(reg_count)-1:0] word;
    logic                         in_range;
    logic [1:0]                   wait_target;
    logic [1:0]                   wait_cnt;
    logic                         answered;
    logic                         access;
    logic                         ready;

    assign word     = req.paddr[$clog2(reg_count)+1:2];
    assign in_range = req.paddr[addr_width-1:$clog2(reg_count)+2] == '0;

    // Wait states follow the low word address bits.
    // Out-of-range answers at once with an error.
    assign wait_target = in_range ? req.paddr[3:2] : 2'd0;

    assign access = req.psel && req.penable && !answered;
    assign ready  = access && (wait_cnt == wait_target);

    // Access cycles seen so far.
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (access && !ready) begin
            wait_cnt <= wait_cnt + 2'd1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // Blocks a second answer while penable stays high.
    always_ff @(posedge clock) begin
        if (reset) begin
            answered <= 1'b0;
        end else if (!req.penable) begin
            answered <= 1'b0;
        end else if (ready) begin
            answered <= 1'b1;
        end
    end

    // Register array with byte strobes.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                mem[i] <= '0;
            end
        end else if (ready && req.pwrite && in_range) begin
            for (int b = 0; b < strb_width; b++) begin
                if (req.pstrb[b]) begin
                    mem[word][b*8 +: 8] <= req.pwdata[b*8 +: 8];
                end
            end
        end
    end

    // Response is only non-zero in the ready cycle.
    always_comb begin
        rsp = '0;
        if (ready) begin
            rsp.pready  = 1'b1;
            rsp.pslverr = !in_range;
            if (in_range && !req.pwrite) begin
                rsp.prdata = mem[word];
            end
        end
    end

endmodule

/* rtl/apb_delayer.sv */
`timescale 1ns/1ps

module apb_delayer
    import apb_pkg::*;
    import delay_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  apb_req_t req,
    output apb_rsp_t rsp,
    output apb_req_t dev_req,
    input  apb_rsp_t dev_rsp
);

    delay_state_t           state;
    logic [delay_width-1:0] delay_acc;
    logic                   delay_done;
    logic [data_width-1:0]  held_prdata;
    logic                   held_pslverr;

    // The request reaches the device untouched.
    assign dev_req = req;

    assign delay_done = (state == hold) && (delay_acc == '0);

    // Setup starts a transfer, device pready ends the access.
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (req.psel && !req.penable) begin
                        state <= active;
                    end
                end
                active: begin
                    if (dev_rsp.pready) begin
                        state <= hold;
                    end
                end
                hold: begin
                    if (delay_acc == '0) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Scaled wait count.
    // Each device wait cycle adds ratio in fixed point, the
    // integer part is then drained one per cycle in hold.
    always_ff @(posedge clock) begin
        if (reset) begin
            delay_acc <= '0;
        end else begin
            case (state)
                active: begin
                    if (dev_rsp.pready) begin
                        delay_acc <= delay_acc >> ratio_shift;
                    end else begin
                        delay_acc <= delay_acc + (delay_width'(ratio) << ratio_shift);
                    end
                end
                hold: begin
                    if (delay_acc != '0) begin
                        delay_acc <= delay_acc - delay_width'(1);
                    end
                end
                default: begin
                    delay_acc <= delay_acc;
                end
            endcase
        end
    end

    // Device response, kept until release.
    always_ff @(posedge clock) begin
        if ((state == active) && dev_rsp.pready) begin
            held_prdata  <= dev_rsp.prdata;
            held_pslverr <= dev_rsp.pslverr;
        end
    end

    // One-cycle registered response pulse.
    always_ff @(posedge clock) begin
        if (reset) begin
            rsp <= '0;
        end else begin
            rsp <= '0;
            if (delay_done) begin
                rsp.pready  <= 1'b1;
                rsp.prdata  <= held_prdata;
                rsp.pslverr <= held_pslverr;
            end
        end
    end

endmodule

/* rtl/delay_pkg.sv */
package delay_pkg;

    // Fixed-point ratio, ratio_shift fraction bits.
    localparam int unsigned ratio_shift = 10;

    // Extra held cycles per device wait cycle.
    localparam int unsigned ratio = 4;

    // Accumulator width.
    localparam int unsigned delay_width = 64;

    // Delayer FSM.
    typedef enum logic [1:0] {
        idle   = 2'd0,
        active = 2'd1,
        hold   = 2'd2
    } delay_state_t;

    // Requester-side performance counts.
    typedef struct packed {
        logic [31:0] transfers;
        logic [31:0] stall_cycles;
    } perf_counts_t;

endpackage

/* rtl/apb_pkg.sv */
package apb_pkg;

    // Bus widths.
    localparam int unsigned addr_width = 32;
    localparam int unsigned data_width = 32;
    localparam int unsigned strb_width = data_width / 8;

    // Number of words in the register peripheral.
    localparam int unsigned reg_count = 16;

    // Requester to completer.
    typedef struct packed {
        logic [addr_width-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic [2:0]            pprot;
        logic                  pwrite;
        logic [data_width-1:0] pwdata;
        logic [strb_width-1:0] pstrb;
    } apb_req_t;

    // Completer to requester.
    // prdata and pslverr are zero outside the pready cycle.
    typedef struct packed {
        logic                  pready;
        logic [data_width-1:0] prdata;
        logic                  pslverr;
    } apb_rsp_t;

endpackage
